// File: hdl/insn_pkg.sv
package insn_pkg;

	// ==================================================
	// Instruction format widths
	// ==================================================

	// Every instruction is one 32-bit word
	localparam int insn_w = 32;
	localparam int reg_idx_w = 5;
	localparam int opcode_w = 6;

	// A decoded record holds pc, opcode, rd, rs1, rs2, imm, uses_imm and illegal
	localparam int dec_rec_w = 32 + opcode_w + 3 * reg_idx_w + 32 + 1 + 1;

	// Opcode class bits
	// Bit 5 selects the I form, bit 4 picks zero extension of the immediate
	localparam int op_imm_bit = 5;
	localparam int op_zext_bit = 4;

	// ==================================================
	// Instruction word, seen in its two forms
	// ==================================================

	// Both forms share opcode, rd and rs1 in the upper 16 bits
	typedef union packed {
		struct packed {
			logic [opcode_w-1:0]  opcode;
			logic [reg_idx_w-1:0] rd;
			logic [reg_idx_w-1:0] rs1;
			logic [reg_idx_w-1:0] rs2;
			logic [10:0]          func;
		} r;
		struct packed {
			logic [opcode_w-1:0]  opcode;
			logic [reg_idx_w-1:0] rd;
			logic [reg_idx_w-1:0] rs1;
			logic [15:0]          imm;
		} i;
	} insn_word_u;

endpackage

// File: hdl/insn_fetch_port.sv
`timescale 1ns/1ps

module insn_fetch_port #(
	parameter logic [31:0] reset_pc = 32'h0000_0000
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      fetch_req,
	input  logic [insn_pkg::insn_w-1:0] fetch_word,
	output logic                      fetch_ack,
	input  logic                      fifo_almost_full,
	output logic                      word_valid,
	output logic [insn_pkg::insn_w-1:0] word,
	output logic [31:0]               pc
);

	// Handshake states
	localparam logic st_idle = 1'b0;
	localparam logic st_acked = 1'b1;

	logic state;
	// Address that the next accepted word will carry
	logic [31:0] next_pc;

	// Ack is high for exactly as long as the machine sits in the acked state
	assign fetch_ack = (state == st_acked);

	// ==================================================
	// Handshake and program counter
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			word_valid <= 1'b0;
			next_pc <= reset_pc;
		end else begin
			// The capture pulse only lasts one cycle
			word_valid <= 1'b0;
			case (state)
				st_idle: begin
					// Hold off the source while the FIFO is nearly full
					if (fetch_req && !fifo_almost_full) begin
						state <= st_acked;
						word_valid <= 1'b1;
						next_pc <= next_pc + 32'd4;
					end
				end
				default: begin
					// Wait for the source to drop req, then release ack
					if (!fetch_req)
						state <= st_idle;
				end
			endcase
		end
	end

	// Word and pc are captured together when a request is accepted
	always_ff @(posedge clk) begin
		if (state == st_idle && fetch_req && !fifo_almost_full) begin
			word <= fetch_word;
			pc <= next_pc;
		end
	end

	// Ack may only rise in answer to a request from the source
	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(fetch_ack) |-> $past(fetch_req));

endmodule

// File: hdl/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         word_valid,
	input  logic [insn_pkg::insn_w-1:0]    word,
	input  logic [31:0]                  pc,
	output logic                         dec_valid,
	output logic [31:0]                  dec_pc,
	output logic [insn_pkg::opcode_w-1:0]  dec_opcode,
	output logic [insn_pkg::reg_idx_w-1:0] dec_rd,
	output logic [insn_pkg::reg_idx_w-1:0] dec_rs1,
	output logic [insn_pkg::reg_idx_w-1:0] dec_rs2,
	output logic [31:0]                  dec_imm,
	output logic                         dec_uses_imm,
	output logic                         dec_illegal
);

	import insn_pkg::*;

	// The same bits read through both instruction forms
	insn_word_u insn;

	logic [reg_idx_w-1:0] rs2_d;
	logic [31:0] imm_d;
	logic uses_imm_d;
	logic illegal_d;

	assign insn = word;

	// ==================================================
	// Form selection and field extraction
	// ==================================================

	always_comb begin
		if (insn.r.opcode[op_imm_bit]) begin
			// I form has no second source register
			rs2_d = '0;
			uses_imm_d = 1'b1;
			illegal_d = 1'b0;
			if (insn.i.opcode[op_zext_bit])
				imm_d = {16'd0, insn.i.imm};
			else
				imm_d = {{16{insn.i.imm[15]}}, insn.i.imm};
		end else begin
			rs2_d = insn.r.rs2;
			imm_d = 32'd0;
			uses_imm_d = 1'b0;
			// Only the low six function bits are defined
			illegal_d = |insn.r.func[10:6];
		end
	end

	// Valid is the only control bit here
	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else
			dec_valid <= word_valid;
	end

	// Decoded fields are loaded only when a new word arrives
	always_ff @(posedge clk) begin
		if (word_valid) begin
			dec_pc <= pc;
			dec_opcode <= insn.r.opcode;
			dec_rd <= insn.r.rd;
			dec_rs1 <= insn.r.rs1;
			dec_rs2 <= rs2_d;
			dec_imm <= imm_d;
			dec_uses_imm <= uses_imm_d;
			dec_illegal <= illegal_d;
		end
	end

endmodule

// File: hdl/insn_fifo.sv
`timescale 1ns/1ps

module insn_fifo #(
	parameter int fifo_depth = 16
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          wr,
	input  logic [insn_pkg::dec_rec_w-1:0] din,
	input  logic                          rd,
	output logic [insn_pkg::dec_rec_w-1:0] dout,
	output logic [$clog2(fifo_depth):0]    cnt,
	output logic                          almost_full,
	output logic                          full,
	output logic                          empty,
	output logic                          v
);

	import insn_pkg::*;

	localparam int ptr_w = $clog2(fifo_depth);
	localparam int cnt_w = ptr_w + 1;

	logic [dec_rec_w-1:0] mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;

	// Pointers wrap at the depth, which need not be a power of two
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(fifo_depth - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// ==================================================
	// Pointer update
	// ==================================================

	// Read and write advance independently, so a push and pop in one cycle
	// leave the count unchanged
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd)
				rd_ptr <= next_ptr(rd_ptr);
		end
	end

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= din;
	end

	// The head is visible without a clock
	assign dout = mem[rd_ptr];

	// ==================================================
	// Occupancy and status flags
	// ==================================================

	always_comb begin
		if (wr_ptr >= rd_ptr)
			cnt = cnt_w'(wr_ptr) - cnt_w'(rd_ptr);
		else
			cnt = cnt_w'(fifo_depth) + cnt_w'(wr_ptr) - cnt_w'(rd_ptr);
	end

	// One slot stays unused, so equal pointers always mean empty
	assign full = (cnt == cnt_w'(fifo_depth - 1));
	assign almost_full = (cnt > cnt_w'(fifo_depth - 5));
	assign empty = (cnt == '0);
	assign v = !empty;

	// Back-pressure upstream must stop writes before the last slot is used
	a_no_wr_full: assert property (@(posedge clk) disable iff (rst) full |-> !wr);
	// The issue stage pops only when it has seen valid data
	a_no_rd_empty: assert property (@(posedge clk) disable iff (rst) empty |-> !rd);

endmodule

// File: hdl/insn_issue_port.sv
`timescale 1ns/1ps

module insn_issue_port (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          fifo_v,
	input  logic [insn_pkg::dec_rec_w-1:0] fifo_dout,
	output logic                          fifo_rd,
	output logic                          issue_req,
	input  logic                          issue_ack,
	output logic [insn_pkg::dec_rec_w-1:0] issue_rec
);

	import insn_pkg::*;

	// Three handshake states
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_wait_hi = 2'd1;
	localparam logic [1:0] st_wait_lo = 2'd2;

	logic [1:0] state;
	// Popped record, held steady for the whole handshake
	logic [dec_rec_w-1:0] hold;

	// Pop as soon as the stage is free and the FIFO has something
	assign fifo_rd = (state == st_idle) && fifo_v;
	assign issue_req = (state == st_wait_hi);
	assign issue_rec = hold;

	// ==================================================
	// Downstream handshake
	// ==================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:
					if (fifo_v)
						state <= st_wait_hi;
				st_wait_hi:
					// Drop req once the consumer has taken the record
					if (issue_ack)
						state <= st_wait_lo;
				default:
					if (!issue_ack)
						state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_rd)
			hold <= fifo_dout;
	end

	// A pending request is never withdrawn before the consumer answers
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		issue_req && !issue_ack |=> issue_req);

endmodule

// File: hdl/insn_frontend_top.sv
`timescale 1ns/1ps

module insn_frontend_top #(
	parameter int fifo_depth = 16,
	parameter logic [31:0] reset_pc = 32'h0000_0000
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          fetch_req,
	input  logic [insn_pkg::insn_w-1:0]     fetch_word,
	output logic                          fetch_ack,
	output logic                          issue_req,
	input  logic                          issue_ack,
	output logic [31:0]                   issue_pc,
	output logic [insn_pkg::opcode_w-1:0]   issue_opcode,
	output logic [insn_pkg::reg_idx_w-1:0]  issue_rd,
	output logic [insn_pkg::reg_idx_w-1:0]  issue_rs1,
	output logic [insn_pkg::reg_idx_w-1:0]  issue_rs2,
	output logic [31:0]                   issue_imm,
	output logic                          issue_uses_imm,
	output logic                          issue_illegal
);

	import insn_pkg::*;

	// Fetch to decode
	logic word_valid;
	logic [insn_w-1:0] word;
	logic [31:0] pc;

	// Decode to FIFO
	logic dec_valid;
	logic [31:0] dec_pc;
	logic [opcode_w-1:0] dec_opcode;
	logic [reg_idx_w-1:0] dec_rd;
	logic [reg_idx_w-1:0] dec_rs1;
	logic [reg_idx_w-1:0] dec_rs2;
	logic [31:0] dec_imm;
	logic dec_uses_imm;
	logic dec_illegal;

	// FIFO to issue
	logic [dec_rec_w-1:0] fifo_din;
	logic [dec_rec_w-1:0] fifo_dout;
	logic fifo_rd;
	logic fifo_v;
	logic fifo_almost_full;
	logic [dec_rec_w-1:0] issue_rec;

	// ==================================================
	// Record packing, pc in the top bits down to the illegal flag
	// ==================================================

	assign fifo_din = {dec_pc, dec_opcode, dec_rd, dec_rs1, dec_rs2,
		dec_imm, dec_uses_imm, dec_illegal};
	assign {issue_pc, issue_opcode, issue_rd, issue_rs1, issue_rs2,
		issue_imm, issue_uses_imm, issue_illegal} = issue_rec;

	insn_fetch_port #(.reset_pc(reset_pc)) fetch0 (
		.clk(clk), .rst(rst),
		.fetch_req(fetch_req), .fetch_word(fetch_word), .fetch_ack(fetch_ack),
		.fifo_almost_full(fifo_almost_full),
		.word_valid(word_valid), .word(word), .pc(pc)
	);

	insn_decoder dec0 (
		.clk(clk), .rst(rst),
		.word_valid(word_valid), .word(word), .pc(pc),
		.dec_valid(dec_valid), .dec_pc(dec_pc), .dec_opcode(dec_opcode),
		.dec_rd(dec_rd), .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_imm(dec_imm),
		.dec_uses_imm(dec_uses_imm), .dec_illegal(dec_illegal)
	);

	// Count, full and empty are only watched inside the FIFO itself
	insn_fifo #(.fifo_depth(fifo_depth)) fifo0 (
		.clk(clk), .rst(rst),
		.wr(dec_valid), .din(fifo_din), .rd(fifo_rd), .dout(fifo_dout),
		.cnt(), .almost_full(fifo_almost_full), .full(), .empty(), .v(fifo_v)
	);

	insn_issue_port issue0 (
		.clk(clk), .rst(rst),
		.fifo_v(fifo_v), .fifo_dout(fifo_dout), .fifo_rd(fifo_rd),
		.issue_req(issue_req), .issue_ack(issue_ack), .issue_rec(issue_rec)
	);

endmodule

// File: verif/tb_insn_frontend.sv
`timescale 1ns/1ps

module tb_insn_frontend;

	import insn_pkg::*;

	localparam int fifo_depth = 16;
	localparam logic [31:0] reset_pc = 32'h0000_1000;
	localparam int num_rows = 24;
	// Row whose ack is held back long enough to fill the FIFO
	localparam int stall_row = 2;
	localparam int stall_cycles = 32;
	localparam int timeout_cycles = num_rows * 40 + 200;

	logic clk;
	logic rst;
	logic fetch_req;
	logic [insn_w-1:0] fetch_word;
	logic fetch_ack;
	logic issue_req;
	logic issue_ack;
	logic [31:0] issue_pc;
	logic [opcode_w-1:0] issue_opcode;
	logic [reg_idx_w-1:0] issue_rd;
	logic [reg_idx_w-1:0] issue_rs1;
	logic [reg_idx_w-1:0] issue_rs2;
	logic [31:0] issue_imm;
	logic issue_uses_imm;
	logic issue_illegal;

	// ==================================================
	// Stimulus table, one row per instruction word
	// ==================================================
	string t_name [num_rows];
	logic [insn_w-1:0] t_word [num_rows];
	logic [opcode_w-1:0] t_op [num_rows];
	logic [reg_idx_w-1:0] t_rd [num_rows];
	logic [reg_idx_w-1:0] t_rs1 [num_rows];
	logic [reg_idx_w-1:0] t_rs2 [num_rows];
	logic [31:0] t_imm [num_rows];
	logic t_uses_imm [num_rows];
	logic t_illegal [num_rows];
	int row_fill = 0;

	logic [16:0] lfsr;
	int cycle_count = 0;
	// Words acked upstream and records acked downstream
	int acked_count = 0;
	int issued_count = 0;
	int peak_backlog = 0;

	insn_frontend_top #(.fifo_depth(fifo_depth), .reset_pc(reset_pc)) dut0 (
		.clk(clk), .rst(rst),
		.fetch_req(fetch_req), .fetch_word(fetch_word), .fetch_ack(fetch_ack),
		.issue_req(issue_req), .issue_ack(issue_ack), .issue_pc(issue_pc),
		.issue_opcode(issue_opcode), .issue_rd(issue_rd), .issue_rs1(issue_rs1),
		.issue_rs2(issue_rs2), .issue_imm(issue_imm),
		.issue_uses_imm(issue_uses_imm), .issue_illegal(issue_illegal)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped on the first mismatch");
	endtask

	// Inputs change and outputs are read 1 ns after each rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// ==================================================
	// Compare tasks, one per result type
	// ==================================================
	task automatic word_equal(input string test, input string field,
		input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp)
			stop_with_error($sformatf("ERROR %s %s: expected %h, actual %h",
				test, field, exp, act));
	endtask

	task automatic reg_equal(input string test, input string field,
		input logic [reg_idx_w-1:0] exp, input logic [reg_idx_w-1:0] act);
		if (act !== exp)
			stop_with_error($sformatf("ERROR %s %s: expected %0d, actual %0d",
				test, field, exp, act));
	endtask

	task automatic opcode_equal(input string test, input string field,
		input logic [opcode_w-1:0] exp, input logic [opcode_w-1:0] act);
		if (act !== exp)
			stop_with_error($sformatf("ERROR %s %s: expected %h, actual %h",
				test, field, exp, act));
	endtask

	task automatic flag_equal(input string test, input string field,
		input logic exp, input logic act);
		if (act !== exp)
			stop_with_error($sformatf("ERROR %s %s: expected %b, actual %b",
				test, field, exp, act));
	endtask

	// Fibonacci LFSR, x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_step(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic random_bits(input int n, output int value);
		value = 0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	// R form, rs2 is used and there is no immediate
	task automatic add_r_row(input string name, input logic [opcode_w-1:0] op,
		input logic [reg_idx_w-1:0] rd, input logic [reg_idx_w-1:0] rs1,
		input logic [reg_idx_w-1:0] rs2, input logic [10:0] func, input logic ill);
		t_name[row_fill] = name;
		t_word[row_fill] = {op, rd, rs1, rs2, func};
		t_op[row_fill] = op;
		t_rd[row_fill] = rd;
		t_rs1[row_fill] = rs1;
		t_rs2[row_fill] = rs2;
		t_imm[row_fill] = 32'd0;
		t_uses_imm[row_fill] = 1'b0;
		t_illegal[row_fill] = ill;
		row_fill++;
	endtask

	// I form, the expected immediate is written out already extended
	task automatic add_i_row(input string name, input logic [opcode_w-1:0] op,
		input logic [reg_idx_w-1:0] rd, input logic [reg_idx_w-1:0] rs1,
		input logic [15:0] imm, input logic [31:0] exp_imm);
		t_name[row_fill] = name;
		t_word[row_fill] = {op, rd, rs1, imm};
		t_op[row_fill] = op;
		t_rd[row_fill] = rd;
		t_rs1[row_fill] = rs1;
		t_rs2[row_fill] = '0;
		t_imm[row_fill] = exp_imm;
		t_uses_imm[row_fill] = 1'b1;
		t_illegal[row_fill] = 1'b0;
		row_fill++;
	endtask

	task automatic fill_table();
		add_r_row("r_add", 6'h01, 5'd3, 5'd1, 5'd2, 11'h000, 1'b0);
		add_r_row("r_sub", 6'h02, 5'd4, 5'd5, 5'd6, 11'h03f, 1'b0);
		add_r_row("r_and", 6'h03, 5'd31, 5'd30, 5'd29, 11'h000, 1'b0);
		add_r_row("r_or", 6'h04, 5'd0, 5'd0, 5'd0, 11'h001, 1'b0);
		add_r_row("r_xor", 6'h1f, 5'd17, 5'd8, 5'd9, 11'h020, 1'b0);
		add_r_row("r_sll", 6'h10, 5'd7, 5'd11, 5'd12, 11'h005, 1'b0);
		add_r_row("r_zero", 6'h00, 5'd0, 5'd0, 5'd0, 11'h000, 1'b0);
		// Any of the upper five function bits makes the word illegal
		add_r_row("r_ill_a", 6'h05, 5'd2, 5'd3, 5'd4, 11'h040, 1'b1);
		add_r_row("r_ill_b", 6'h06, 5'd9, 5'd10, 5'd11, 11'h400, 1'b1);
		add_r_row("r_ill_c", 6'h0a, 5'd1, 5'd2, 5'd3, 11'h7ff, 1'b1);
		// Opcode bit 4 clear gives sign extension
		add_i_row("i_addi_pos", 6'h20, 5'd5, 5'd6, 16'h0123, 32'h0000_0123);
		add_i_row("i_addi_neg", 6'h21, 5'd7, 5'd8, 16'hffff, 32'hffff_ffff);
		add_i_row("i_ld", 6'h2a, 5'd12, 5'd13, 16'h8000, 32'hffff_8000);
		add_i_row("i_st", 6'h2f, 5'd31, 5'd31, 16'h7fff, 32'h0000_7fff);
		add_i_row("i_slti", 6'h25, 5'd1, 5'd2, 16'habcd, 32'hffff_abcd);
		add_i_row("i_zero_s", 6'h20, 5'd0, 5'd0, 16'h0000, 32'h0000_0000);
		// Opcode bit 4 set gives zero extension
		add_i_row("i_ori", 6'h30, 5'd3, 5'd4, 16'hffff, 32'h0000_ffff);
		add_i_row("i_andi", 6'h31, 5'd14, 5'd15, 16'h8001, 32'h0000_8001);
		add_i_row("i_lui", 6'h3f, 5'd20, 5'd0, 16'h1234, 32'h0000_1234);
		add_i_row("i_xori", 6'h38, 5'd21, 5'd22, 16'habcd, 32'h0000_abcd);
		add_r_row("r_mul", 6'h0c, 5'd23, 5'd24, 5'd25, 11'h002, 1'b0);
		add_i_row("i_neg_b", 6'h2c, 5'd26, 5'd27, 16'h8765, 32'hffff_8765);
		add_r_row("r_ill_d", 6'h1e, 5'd28, 5'd29, 5'd30, 11'h0c0, 1'b1);
		add_i_row("i_zx_top", 6'h3a, 5'd30, 5'd31, 16'hf00f, 32'h0000_f00f);
	endtask

	// ==================================================
	// Upstream producer and downstream consumer
	// ==================================================
	task automatic feed_words();
		for (int i = 0; i < num_rows; i++) begin
			fetch_word = t_word[i];
			fetch_req = 1'b1;
			do
				next_cycle();
			while (!fetch_ack);
			acked_count++;
			fetch_req = 1'b0;
			do
				next_cycle();
			while (fetch_ack);
		end
	endtask

	task automatic drain_records();
		int gap;
		for (int i = 0; i < num_rows; i++) begin
			while (!issue_req)
				next_cycle();
			word_equal(t_name[i], "pc", reset_pc + 32'(i) * 32'd4, issue_pc);
			opcode_equal(t_name[i], "opcode", t_op[i], issue_opcode);
			reg_equal(t_name[i], "rd", t_rd[i], issue_rd);
			reg_equal(t_name[i], "rs1", t_rs1[i], issue_rs1);
			reg_equal(t_name[i], "rs2", t_rs2[i], issue_rs2);
			word_equal(t_name[i], "imm", t_imm[i], issue_imm);
			flag_equal(t_name[i], "uses_imm", t_uses_imm[i], issue_uses_imm);
			flag_equal(t_name[i], "illegal", t_illegal[i], issue_illegal);
			if (i == stall_row) begin
				repeat (stall_cycles)
					next_cycle();
				// A long stall has to push the FIFO into its almost full band
				if (peak_backlog <= fifo_depth - 5)
					stop_with_error("Upstream was never throttled during the consumer stall");
			end else begin
				random_bits(2, gap);
				repeat (gap)
					next_cycle();
			end
			issue_ack = 1'b1;
			issued_count++;
			do
				next_cycle();
			while (issue_req);
			issue_ack = 1'b0;
		end
	endtask

	// Backlog bound, read after both handshake processes have moved
	initial begin
		while (acked_count - issued_count <= fifo_depth + 1) begin
			if (acked_count - issued_count > peak_backlog)
				peak_backlog = acked_count - issued_count;
			@(posedge clk);
			#2;
		end
		stop_with_error($sformatf("Upstream got %0d words ahead of the issue stage",
			acked_count - issued_count));
	end

	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge clk);
			cycle_count++;
		end
		stop_with_error($sformatf("Run did not complete within %0d cycles",
			timeout_cycles));
	end

	initial begin
		rst = 1'b1;
		fetch_req = 1'b0;
		fetch_word = '0;
		issue_ack = 1'b0;
		lfsr = 17'd89224;
		fill_table();
		repeat (3)
			@(posedge clk);
		#1;
		rst = 1'b0;
		// Both links are quiet straight out of reset
		flag_equal("reset", "fetch_ack", 1'b0, fetch_ack);
		flag_equal("reset", "issue_req", 1'b0, issue_req);
		fork
			feed_words();
			drain_records();
		join
		// Nothing extra may come out once the table is drained
		repeat (20) begin
			next_cycle();
			flag_equal("drain", "issue_req", 1'b0, issue_req);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: compile.f
hdl/insn_pkg.sv
hdl/insn_fetch_port.sv
hdl/insn_decoder.sv
hdl/insn_fifo.sv
hdl/insn_issue_port.sv
hdl/insn_frontend_top.sv
verif/tb_insn_frontend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the instruction front end with its testbench, then run it
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -j 0 \
	--top-module tb_insn_frontend \
	-f compile.f \
	-o tb_insn_frontend &&
./obj_dir/tb_insn_frontend || exit 1
